/* hdl/rv_pkg.sv */
package rv_pkg;

	localparam int xlen = 32;
	localparam int reg_addr_w = 5;

	// major opcodes.
	localparam logic [6:0] op_lui    = 7'b0110111;
	localparam logic [6:0] op_auipc  = 7'b0010111;
	localparam logic [6:0] op_jal    = 7'b1101111;
	localparam logic [6:0] op_jalr   = 7'b1100111;
	localparam logic [6:0] op_branch = 7'b1100011;
	localparam logic [6:0] op_load   = 7'b0000011;
	localparam logic [6:0] op_store  = 7'b0100011;
	localparam logic [6:0] op_imm    = 7'b0010011;
	localparam logic [6:0] op_reg    = 7'b0110011;

	typedef enum logic [3:0] {
		alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor,
		alu_srl, alu_sra, alu_or, alu_and, alu_pass_b, alu_link
	} alu_op_e;

	typedef enum logic [3:0] {
		br_none, br_eq, br_ne, br_lt, br_ge, br_ltu, br_geu, br_jal, br_jalr
	} br_op_e;

	typedef struct packed {
		logic [xlen-1:0] pc;
		logic [xlen-1:0] instr;
	} fetch_t;

	typedef struct packed {
		logic [xlen-1:0] pc;
		logic [xlen-1:0] instr;
		logic [xlen-1:0] op_a;
		logic [xlen-1:0] op_b;
		logic [xlen-1:0] imm;
		logic [xlen-1:0] rs1_data; // jalr base.
		logic [reg_addr_w-1:0] rd;
		logic wr_en;
		alu_op_e alu_op;
		br_op_e br_op;
		logic illegal;
	} exe_t;

	typedef struct packed {
		logic [xlen-1:0] pc;
		logic [xlen-1:0] instr;
		logic [reg_addr_w-1:0] rd;
		logic wr_en;
		logic [xlen-1:0] wr_data;
		logic br_taken;
		logic [xlen-1:0] next_pc;
		logic illegal;
	} retire_t;

endpackage

/* hdl/stage_if.sv */
interface stage_if #(
	parameter type payload_t = logic
);

	logic valid;
	payload_t data;
	logic stall; // consumer cannot take data this cycle.

	modport producer
	(
		output valid,
		output data,
		input stall
	);

	modport consumer
	(
		input valid,
		input data,
		output stall
	);

endinterface

/* hdl/credit_fifo.sv */
module credit_fifo #(
	parameter int depth = 4,
	parameter type payload_t = logic
) (
	input logic clk,
	input logic reset,
	input logic push,
	input payload_t push_data,
	input logic pop,
	output payload_t head,
	output logic empty,
	output logic [$clog2(depth + 1)-1:0] count,
	output logic credit
);

	localparam int aw = (depth > 1) ? $clog2(depth) : 1;

	payload_t mem [depth];
	logic [aw-1:0] wr_ptr;
	logic [aw-1:0] rd_ptr;

	function automatic logic [aw-1:0] next_ptr(input logic [aw-1:0] ptr);
		next_ptr = (ptr == aw'(depth - 1)) ? '0 : ptr + 1'b1;
	endfunction

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			credit <= 1'b0;
		end
		else
		begin
			if (push)
				wr_ptr <= next_ptr(wr_ptr);
			if (pop)
				rd_ptr <= next_ptr(rd_ptr);
			count <= count + push - pop;
			credit <= pop; // one credit back per freed entry.
		end
	end

	always_ff @(posedge clk)
	begin
		if (push)
			mem[wr_ptr] <= push_data;
	end

	assign head = mem[rd_ptr];
	assign empty = (count == '0);

	// sender must never run past its credits.
	a_no_overflow: assert property (@(posedge clk) disable iff (reset)
		!(push && !pop && count == depth));
	a_no_underflow: assert property (@(posedge clk) disable iff (reset)
		!(pop && empty));

endmodule

/* hdl/regfile.sv */
module regfile
	import rv_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic [reg_addr_w-1:0] rs1_addr,
	input logic [reg_addr_w-1:0] rs2_addr,
	output logic [xlen-1:0] rs1_data,
	output logic [xlen-1:0] rs2_data,
	input logic [reg_addr_w-1:0] rd_addr,
	input logic [xlen-1:0] rd_data,
	input logic wr_en
);

	logic [xlen-1:0] regs [32];

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end
		else if (wr_en && rd_addr != '0)
			regs[rd_addr] <= rd_data;
	end

	// write-through so writeback is seen by decode in the same cycle.
	assign rs1_data = (rs1_addr == '0) ? '0 :
		(wr_en && rd_addr == rs1_addr) ? rd_data : regs[rs1_addr];
	assign rs2_data = (rs2_addr == '0) ? '0 :
		(wr_en && rd_addr == rs2_addr) ? rd_data : regs[rs2_addr];

endmodule

/* hdl/decode.sv */
module decode
	import rv_pkg::*;
(
	input logic clk,
	input logic reset,
	input fetch_t head,
	input logic empty,
	input logic slot_free,
	output logic pop,
	stage_if.producer id,
	stage_if.consumer wb
);

	typedef enum logic [2:0] {imm_i, imm_s, imm_b, imm_u, imm_j} imm_sel_e;

	logic [xlen-1:0] instr;
	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic [reg_addr_w-1:0] rs1;
	logic [reg_addr_w-1:0] rs2;
	logic [xlen-1:0] rs1_data;
	logic [xlen-1:0] rs2_data;
	logic [xlen-1:0] imm;
	imm_sel_e imm_sel;
	alu_op_e alu_op;
	br_op_e br_op;
	logic a_pc, b_imm, use_rs1, use_rs2, wr_en, illegal;
	logic hazard;
	exe_t nxt;

	function automatic alu_op_e alu_sel(input logic [2:0] f3, input logic alt);
		case (f3)
			3'b000: alu_sel = alt ? alu_sub : alu_add;
			3'b001: alu_sel = alu_sll;
			3'b010: alu_sel = alu_slt;
			3'b011: alu_sel = alu_sltu;
			3'b100: alu_sel = alu_xor;
			3'b101: alu_sel = alt ? alu_sra : alu_srl;
			3'b110: alu_sel = alu_or;
			default: alu_sel = alu_and;
		endcase
	endfunction

	assign instr = head.instr;
	assign opcode = instr[6:0];
	assign funct3 = instr[14:12];
	assign funct7 = instr[31:25];
	assign rs1 = instr[19:15];
	assign rs2 = instr[24:20];

	// writeback port; wb.stall is owned by retire_port.
	regfile regfile_i (
		.clk(clk),
		.reset(reset),
		.rs1_addr(rs1),
		.rs2_addr(rs2),
		.rs1_data(rs1_data),
		.rs2_data(rs2_data),
		.rd_addr(wb.data.rd),
		.rd_data(wb.data.wr_data),
		.wr_en(wb.valid && wb.data.wr_en)
	);

	always_comb
	begin
		alu_op = alu_add;
		br_op = br_none;
		imm_sel = imm_i;
		a_pc = 1'b0;
		b_imm = 1'b0;
		use_rs1 = 1'b0;
		use_rs2 = 1'b0;
		wr_en = 1'b0;
		illegal = 1'b0;
		case (opcode)
			op_lui:
			begin
				alu_op = alu_pass_b;
				imm_sel = imm_u;
				b_imm = 1'b1;
				wr_en = 1'b1;
			end
			op_auipc:
			begin
				imm_sel = imm_u;
				a_pc = 1'b1;
				b_imm = 1'b1;
				wr_en = 1'b1;
			end
			op_jal:
			begin
				alu_op = alu_link;
				br_op = br_jal;
				imm_sel = imm_j;
				wr_en = 1'b1;
			end
			op_jalr:
			begin
				alu_op = alu_link;
				br_op = br_jalr;
				use_rs1 = 1'b1;
				wr_en = 1'b1;
				illegal = (funct3 != 3'b000);
			end
			op_branch:
			begin
				imm_sel = imm_b;
				use_rs1 = 1'b1;
				use_rs2 = 1'b1;
				case (funct3)
					3'b000: br_op = br_eq;
					3'b001: br_op = br_ne;
					3'b100: br_op = br_lt;
					3'b101: br_op = br_ge;
					3'b110: br_op = br_ltu;
					3'b111: br_op = br_geu;
					default: illegal = 1'b1;
				endcase
			end
			op_imm:
			begin
				alu_op = alu_sel(funct3, funct3 == 3'b101 && instr[30]);
				b_imm = 1'b1;
				use_rs1 = 1'b1;
				wr_en = 1'b1;
				illegal = (funct3 == 3'b001 && funct7 != 7'b0) ||
					(funct3 == 3'b101 && funct7 != 7'b0 && funct7 != 7'b0100000);
			end
			op_reg:
			begin
				alu_op = alu_sel(funct3, instr[30]);
				use_rs1 = 1'b1;
				use_rs2 = 1'b1;
				wr_en = 1'b1;
				illegal = !(funct7 == 7'b0 || (funct7 == 7'b0100000 &&
					(funct3 == 3'b000 || funct3 == 3'b101)));
			end
			op_store:
			begin
				imm_sel = imm_s;
				illegal = 1'b1;
			end
			default: illegal = 1'b1; // loads, fence, system.
		endcase
		if (illegal)
		begin
			wr_en = 1'b0;
			br_op = br_none;
		end
	end

	always_comb
	begin
		case (imm_sel)
			imm_s: imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
			imm_b: imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
				instr[11:8], 1'b0};
			imm_u: imm = {instr[31:12], 12'b0};
			imm_j: imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
				instr[30:21], 1'b0};
			default: imm = {{20{instr[31]}}, instr[31:20]};
		endcase
	end

	// the one case the write-through misses: producer still in ID/EXE.
	assign hazard = id.valid && id.data.wr_en && id.data.rd != '0 &&
		((use_rs1 && rs1 == id.data.rd) || (use_rs2 && rs2 == id.data.rd));
	assign pop = !empty && !hazard && slot_free && !id.stall;

	always_comb
	begin
		nxt.pc = head.pc;
		nxt.instr = instr;
		nxt.op_a = a_pc ? head.pc : rs1_data;
		nxt.op_b = b_imm ? imm : rs2_data;
		nxt.imm = imm;
		nxt.rs1_data = rs1_data;
		nxt.rd = instr[11:7];
		nxt.wr_en = wr_en;
		nxt.alu_op = alu_op;
		nxt.br_op = br_op;
		nxt.illegal = illegal;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			id.valid <= 1'b0;
		else if (!id.stall)
			id.valid <= pop; // bubble when nothing issues.
	end

	always_ff @(posedge clk)
	begin
		if (pop)
			id.data <= nxt;
	end

endmodule

/* hdl/execute.sv */
module execute
	import rv_pkg::*;
(
	input logic clk,
	input logic reset,
	stage_if.consumer id,
	stage_if.producer wb
);

	logic [xlen-1:0] a, b;
	logic [4:0] shamt;
	logic [xlen-1:0] pc_plus4;
	logic [xlen-1:0] jalr_sum;
	logic [xlen-1:0] target;
	logic [xlen-1:0] alu_res;
	logic taken;
	retire_t rec;

	assign a = id.data.op_a;
	assign b = id.data.op_b;
	assign shamt = b[4:0];
	assign pc_plus4 = id.data.pc + 32'd4;

	always_comb
	begin
		case (id.data.alu_op)
			alu_sub: alu_res = a - b;
			alu_sll: alu_res = a << shamt;
			alu_slt: alu_res = {{(xlen-1){1'b0}}, $signed(a) < $signed(b)};
			alu_sltu: alu_res = {{(xlen-1){1'b0}}, a < b};
			alu_xor: alu_res = a ^ b;
			alu_srl: alu_res = a >> shamt;
			alu_sra: alu_res = $signed(a) >>> shamt;
			alu_or: alu_res = a | b;
			alu_and: alu_res = a & b;
			alu_pass_b: alu_res = b;
			alu_link: alu_res = pc_plus4;
			default: alu_res = a + b;
		endcase
	end

	// branches carry rs1/rs2 in op_a/op_b.
	always_comb
	begin
		case (id.data.br_op)
			br_eq: taken = (a == b);
			br_ne: taken = (a != b);
			br_lt: taken = $signed(a) < $signed(b);
			br_ge: taken = $signed(a) >= $signed(b);
			br_ltu: taken = a < b;
			br_geu: taken = a >= b;
			br_jal, br_jalr: taken = 1'b1;
			default: taken = 1'b0;
		endcase
	end

	assign jalr_sum = id.data.rs1_data + id.data.imm;
	assign target = (id.data.br_op == br_jalr) ? {jalr_sum[xlen-1:1], 1'b0} :
		id.data.pc + id.data.imm;

	always_comb
	begin
		rec.pc = id.data.pc;
		rec.instr = id.data.instr;
		rec.rd = id.data.rd;
		rec.wr_en = id.data.wr_en;
		rec.wr_data = alu_res;
		rec.br_taken = taken;
		rec.next_pc = taken ? target : pc_plus4;
		rec.illegal = id.data.illegal;
	end

	assign id.stall = wb.valid && wb.stall;

	always_ff @(posedge clk)
	begin
		if (reset)
			wb.valid <= 1'b0;
		else if (!id.stall)
			wb.valid <= id.valid;
	end

	always_ff @(posedge clk)
	begin
		if (id.valid && !id.stall)
			wb.data <= rec;
	end

endmodule

/* hdl/retire_port.sv */
module retire_port
	import rv_pkg::*;
#(
	parameter int depth = 4
) (
	input logic clk,
	input logic reset,
	stage_if.consumer wb,
	input logic issued,
	output logic slot_free,
	output logic out_valid,
	output retire_t out_rec,
	input logic out_credit
);

	localparam int cw = $clog2(depth + 1);

	logic [cw-1:0] count;
	logic [cw-1:0] inflight; // issued but not yet buffered.
	logic [cw-1:0] credits;
	logic [cw:0] used;
	logic empty;
	logic push;

	credit_fifo #(
		.depth(depth),
		.payload_t(retire_t)
	) buf_i (
		.clk(clk),
		.reset(reset),
		.push(push),
		.push_data(wb.data),
		.pop(out_valid),
		.head(out_rec),
		.empty(empty),
		.count(count),
		.credit()
	);

	assign wb.stall = (count == cw'(depth));
	assign push = wb.valid && !wb.stall;

	assign used = count + inflight;
	assign slot_free = (used < depth);
	assign out_valid = !empty && credits != '0;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			inflight <= '0;
			credits <= cw'(depth);
		end
		else
		begin
			inflight <= inflight + issued - push;
			credits <= credits - out_valid + out_credit;
		end
	end

	a_credit_bound: assert property (@(posedge clk) disable iff (reset)
		credits <= depth);

endmodule

/* hdl/exec_slice_top.sv */
module exec_slice_top
	import rv_pkg::*;
#(
	parameter int in_depth = 4,
	parameter int out_depth = 4
) (
	input logic clk,
	input logic reset,
	input logic in_valid,
	input logic [xlen-1:0] in_pc,
	input logic [xlen-1:0] in_instr,
	output logic in_credit,
	output logic out_valid,
	output logic [xlen-1:0] out_pc,
	output logic [xlen-1:0] out_instr,
	output logic [reg_addr_w-1:0] out_rd,
	output logic out_wr_en,
	output logic [xlen-1:0] out_wr_data,
	output logic out_br_taken,
	output logic [xlen-1:0] out_next_pc,
	output logic out_illegal,
	input logic out_credit
);

	fetch_t in_rec;
	fetch_t head;
	logic empty;
	logic pop;
	logic slot_free;
	retire_t out_rec;

	stage_if #(.payload_t(exe_t)) id_if ();
	stage_if #(.payload_t(retire_t)) wb_if ();

	assign in_rec.pc = in_pc;
	assign in_rec.instr = in_instr;

	credit_fifo #(.depth(in_depth), .payload_t(fetch_t)) in_fifo_i (
		.clk(clk), .reset(reset),
		.push(in_valid), .push_data(in_rec),
		.pop(pop), .head(head), .empty(empty),
		.count(), .credit(in_credit)
	);

	decode decode_i (
		.clk(clk), .reset(reset),
		.head(head), .empty(empty), .slot_free(slot_free), .pop(pop),
		.id(id_if.producer), .wb(wb_if.consumer)
	);

	execute execute_i (.clk(clk), .reset(reset), .id(id_if.consumer), .wb(wb_if.producer));

	retire_port #(.depth(out_depth)) retire_port_i (
		.clk(clk), .reset(reset),
		.wb(wb_if.consumer), .issued(pop), .slot_free(slot_free),
		.out_valid(out_valid), .out_rec(out_rec), .out_credit(out_credit)
	);

	assign out_pc = out_rec.pc;
	assign out_instr = out_rec.instr;
	assign out_rd = out_rec.rd;
	assign out_wr_en = out_rec.wr_en;
	assign out_wr_data = out_rec.wr_data;
	assign out_br_taken = out_rec.br_taken;
	assign out_next_pc = out_rec.next_pc;
	assign out_illegal = out_rec.illegal;

endmodule

/* verif/result_checker.sv */
module result_checker
	import rv_pkg::*;
#(
	parameter int n_rows = 1,
	parameter int out_depth = 4
) (
	input logic clk,
	input logic reset,
	input retire_t rows [n_rows],
	input logic out_valid,
	input logic [xlen-1:0] out_pc,
	input logic [xlen-1:0] out_instr,
	input logic [reg_addr_w-1:0] out_rd,
	input logic out_wr_en,
	input logic [xlen-1:0] out_wr_data,
	input logic out_br_taken,
	input logic [xlen-1:0] out_next_pc,
	input logic out_illegal,
	input logic out_credit,
	input logic in_credit,
	input int sent,
	input logic end_check,
	output int errors,
	output int received,
	output int in_credits
);

	timeunit 1ns;
	timeprecision 1ps;

	int credits; // credits the DUT holds toward the consumer.

	task automatic compare_field(input string name, input logic [xlen-1:0] got,
		input logic [xlen-1:0] want);
		if (got !== want)
		begin
			$display("FAILED %s in record %0d at pc %h: got %h, expected %h",
				name, received, rows[received].pc, got, want);
			errors++;
		end
	endtask

	always @(posedge clk)
	begin
		retire_t want;
		if (reset)
		begin
			errors = 0;
			received = 0;
			in_credits = 0;
			credits = out_depth;
		end
		else
		begin
			if (in_credit)
				in_credits++;
			if (out_valid)
			begin
				if (credits <= 0)
				begin
					$display("output credit overrun, record at pc %h sent without a credit",
						out_pc);
					errors++;
				end
				if (received >= n_rows)
				begin
					$display("extra record at pc %h after all %0d expected records",
						out_pc, n_rows);
					errors++;
				end
				else
				begin
					want = rows[received];
					compare_field("out_pc", out_pc, want.pc);
					compare_field("out_instr", out_instr, want.instr);
					compare_field("out_wr_en", xlen'(out_wr_en), xlen'(want.wr_en));
					if (want.wr_en) // rd and data mean nothing without a write.
					begin
						compare_field("out_rd", xlen'(out_rd), xlen'(want.rd));
						compare_field("out_wr_data", out_wr_data, want.wr_data);
					end
					compare_field("out_br_taken", xlen'(out_br_taken), xlen'(want.br_taken));
					compare_field("out_next_pc", out_next_pc, want.next_pc);
					compare_field("out_illegal", xlen'(out_illegal), xlen'(want.illegal));
					received++;
				end
			end
			credits = credits - out_valid + out_credit;
			if (end_check)
			begin
				if (received != n_rows)
				begin
					$display("missing records, only %0d of %0d retired", received, n_rows);
					errors++;
				end
				if (in_credits != sent)
				begin
					$display("in_credit pulsed %0d times for %0d instructions sent",
						in_credits, sent);
					errors++;
				end
			end
		end
	end

endmodule

/* verif/tb_top.sv */
module tb_top
	import rv_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int in_depth = 4;
	localparam int out_depth = 4;
	localparam int n_rows = 34;
	localparam int reset_cycles = 10;
	localparam int cycle_limit = n_rows * 40 + reset_cycles;

	logic clk = 1'b0;
	logic reset;
	logic in_valid;
	logic [xlen-1:0] in_pc;
	logic [xlen-1:0] in_instr;
	logic in_credit;
	logic out_valid;
	logic [xlen-1:0] out_pc;
	logic [xlen-1:0] out_instr;
	logic [reg_addr_w-1:0] out_rd;
	logic out_wr_en;
	logic [xlen-1:0] out_wr_data;
	logic out_br_taken;
	logic [xlen-1:0] out_next_pc;
	logic out_illegal;
	logic out_credit = 1'b0;
	logic end_check;

	retire_t rows [n_rows]; // stimulus in pc and instr, the rest is expected.
	int n_set = 0;
	int sent = 0;
	int held;
	int cycles = 0;
	int seed;
	int due [$]; // cycles at which consumer credits go back.
	int errors;
	int received;
	int in_credits;
	bit timed_out;

	exec_slice_top #(
		.in_depth(in_depth),
		.out_depth(out_depth)
	) exec_slice_top_i (
		.clk(clk),
		.reset(reset),
		.in_valid(in_valid),
		.in_pc(in_pc),
		.in_instr(in_instr),
		.in_credit(in_credit),
		.out_valid(out_valid),
		.out_pc(out_pc),
		.out_instr(out_instr),
		.out_rd(out_rd),
		.out_wr_en(out_wr_en),
		.out_wr_data(out_wr_data),
		.out_br_taken(out_br_taken),
		.out_next_pc(out_next_pc),
		.out_illegal(out_illegal),
		.out_credit(out_credit)
	);

	result_checker #(
		.n_rows(n_rows),
		.out_depth(out_depth)
	) result_checker_i (
		.clk(clk),
		.reset(reset),
		.rows(rows),
		.out_valid(out_valid),
		.out_pc(out_pc),
		.out_instr(out_instr),
		.out_rd(out_rd),
		.out_wr_en(out_wr_en),
		.out_wr_data(out_wr_data),
		.out_br_taken(out_br_taken),
		.out_next_pc(out_next_pc),
		.out_illegal(out_illegal),
		.out_credit(out_credit),
		.in_credit(in_credit),
		.sent(sent),
		.end_check(end_check),
		.errors(errors),
		.received(received),
		.in_credits(in_credits)
	);

	always #50 clk = ~clk;

	always @(posedge clk)
		cycles <= cycles + 1;

	task automatic set_row(input logic [xlen-1:0] instr, input int rd, input bit wr_en,
		input logic [xlen-1:0] wr_data, input bit taken, input logic [xlen-1:0] next_pc,
		input bit illegal);
		rows[n_set].pc = xlen'(n_set * 4);
		rows[n_set].instr = instr;
		rows[n_set].rd = reg_addr_w'(rd);
		rows[n_set].wr_en = wr_en;
		rows[n_set].wr_data = wr_data;
		rows[n_set].br_taken = taken;
		rows[n_set].next_pc = next_pc;
		rows[n_set].illegal = illegal;
		n_set++;
	endtask

	// x1 = 5 and x2 = -3 feed most of the later rows.
	task automatic load_table();
		set_row(32'h00500093, 1, 1, 32'h00000005, 0, 32'h04, 0); // addi x1, x0, 5.
		set_row(32'hffd00113, 2, 1, 32'hfffffffd, 0, 32'h08, 0); // addi x2, x0, -3.
		set_row(32'h002081b3, 3, 1, 32'h00000002, 0, 32'h0c, 0); // add x3, x1, x2.
		set_row(32'h40208233, 4, 1, 32'h00000008, 0, 32'h10, 0); // sub x4, x1, x2.
		set_row(32'h0020c2b3, 5, 1, 32'hfffffff8, 0, 32'h14, 0); // xor x5, x1, x2.
		set_row(32'h0020e333, 6, 1, 32'hfffffffd, 0, 32'h18, 0); // or x6, x1, x2.
		set_row(32'h0f017393, 7, 1, 32'h000000f0, 0, 32'h1c, 0); // andi x7, x2, 0xf0.
		set_row(32'h00409413, 8, 1, 32'h00000050, 0, 32'h20, 0); // slli x8, x1, 4.
		set_row(32'h40115493, 9, 1, 32'hfffffffe, 0, 32'h24, 0); // srai x9, x2, 1.
		set_row(32'h01c15513, 10, 1, 32'h0000000f, 0, 32'h28, 0); // srli x10, x2, 28.
		set_row(32'h001125b3, 11, 1, 32'h00000001, 0, 32'h2c, 0); // slt x11, x2, x1.
		set_row(32'h00113633, 12, 1, 32'h00000000, 0, 32'h30, 0); // sltu x12, x2, x1.
		set_row(32'h123456b7, 13, 1, 32'h12345000, 0, 32'h34, 0); // lui x13, 0x12345.
		set_row(32'h00001717, 14, 1, 32'h00001034, 0, 32'h38, 0); // auipc x14, 0x1.
		set_row(32'h00708013, 0, 1, 32'h0000000c, 0, 32'h3c, 0); // addi x0, x1, 7.
		set_row(32'h00d007b3, 15, 1, 32'h12345000, 0, 32'h40, 0); // add x15, x0, x13.
		set_row(32'h00108463, 0, 0, 32'h0, 1, 32'h48, 0); // beq x1, x1, 8.
		set_row(32'h00109463, 0, 0, 32'h0, 0, 32'h48, 0); // bne x1, x1, 8.
		set_row(32'hfe1148e3, 0, 0, 32'h0, 1, 32'h38, 0); // blt x2, x1, -16.
		set_row(32'h00117663, 0, 0, 32'h0, 1, 32'h58, 0); // bgeu x2, x1, 12.
		set_row(32'h00115663, 0, 0, 32'h0, 0, 32'h54, 0); // bge x2, x1, 12.
		set_row(32'h0020e463, 0, 0, 32'h0, 1, 32'h5c, 0); // bltu x1, x2, 8.
		set_row(32'h0020c463, 0, 0, 32'h0, 0, 32'h5c, 0); // blt x1, x2, 8.
		set_row(32'h0020d463, 0, 0, 32'h0, 1, 32'h64, 0); // bge x1, x2, 8.
		set_row(32'h00116463, 0, 0, 32'h0, 0, 32'h64, 0); // bltu x2, x1, 8.
		set_row(32'h0020f463, 0, 0, 32'h0, 0, 32'h68, 0); // bgeu x1, x2, 8.
		set_row(32'h1000086f, 16, 1, 32'h0000006c, 1, 32'h168, 0); // jal x16, 0x100.
		set_row(32'h003408e7, 17, 1, 32'h00000070, 1, 32'h52, 0); // jalr x17, 3(x8).
		set_row(32'h0000a903, 0, 0, 32'h0, 0, 32'h74, 1); // lw x18, 0(x1).
		set_row(32'h00112223, 0, 0, 32'h0, 0, 32'h78, 1); // sw x1, 4(x2), rd field is x4.
		set_row(32'h00000073, 0, 0, 32'h0, 0, 32'h7c, 1); // ecall.
		set_row(32'h000909b3, 19, 1, 32'h00000000, 0, 32'h80, 0); // add x19, x18, x0.
		set_row(32'h00418463, 0, 0, 32'h0, 0, 32'h84, 0); // beq x3, x4, 8.
		set_row(32'h01181463, 0, 0, 32'h0, 1, 32'h8c, 0); // bne x16, x17, 8.
	endtask

	// consumer frees each record 0 to 3 cycles after it arrives.
	always @(posedge clk)
	begin
		bit beat;
		int pick;
		beat = out_valid && !reset;
		#1;
		if (beat)
			due.push_back(cycles + ($random(seed) & 3));
		pick = -1;
		foreach (due[i])
			if (pick < 0 && due[i] <= cycles)
				pick = i;
		if (pick >= 0)
			due.delete(pick);
		out_credit = (pick >= 0);
	end

	initial
	begin
		seed = 32'hfce6_f1f1;
		reset = 1'b1;
		in_valid = 1'b0;
		in_pc = '0;
		in_instr = '0;
		end_check = 1'b0;
		timed_out = 1'b0;
		load_table();
		repeat (reset_cycles) @(posedge clk);
		#1;
		reset = 1'b0;
		held = in_depth;
		while (sent < n_rows && cycles < cycle_limit)
		begin
			@(posedge clk);
			#1;
			if (in_credit)
				held++;
			if (held > 0)
			begin
				in_valid = 1'b1;
				in_pc = rows[sent].pc;
				in_instr = rows[sent].instr;
				held--;
				sent++;
			end
			else
				in_valid = 1'b0;
		end
		@(posedge clk);
		#1;
		in_valid = 1'b0;
		while (received < n_rows && cycles < cycle_limit)
		begin
			@(posedge clk);
			#1;
		end
		timed_out = (received < n_rows);
		if (!timed_out)
		begin
			repeat (20) @(posedge clk); // room for a stray extra record.
			#1;
			end_check = 1'b1;
			@(posedge clk);
			#1;
			end_check = 1'b0;
		end
		else
			$display("timeout after %0d cycles with %0d of %0d records retired",
				cycles, received, n_rows);
		$display("errors %0d, records %0d of %0d, input credits %0d of %0d sent",
			errors, received, n_rows, in_credits, sent);
		if (timed_out || errors != 0)
			$display("Regression failed");
		else
			$display("Regression passed");
		$finish;
	end

endmodule

/* sim.f */
hdl/rv_pkg.sv
hdl/stage_if.sv
hdl/credit_fifo.sv
hdl/regfile.sv
hdl/decode.sv
hdl/execute.sv
hdl/retire_port.sv
hdl/exec_slice_top.sv
verif/result_checker.sv
verif/tb_top.sv

/* Makefile */
SRCS := $(wildcard hdl/*.sv verif/*.sv)

.PHONY: all run clean

all: run

obj_dir/Vtb_top: sim.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_top -Mdir obj_dir -f sim.f

run: obj_dir/Vtb_top
	./obj_dir/Vtb_top > sim.log 2>&1; cat sim.log
	@if grep -q "Regression failed" sim.log; then exit 1; fi
	@grep -q "Regression passed" sim.log

clean:
	rm -rf obj_dir sim.log
